/* dv/access_patterns.hex */
// op addr wdata expected hit, one access per line, all hex
// op 0 read, 1 write, f ends the list; hit 1 means pready in the cycle after the first access
0 0010 0000 0010 0
0 0012 0000 0012 1
0 0013 0000 0013 1
0 1234 0000 0234 0
0 1236 0000 0236 1
1 0011 beef 0000 0
0 0011 0000 beef 1
0 0010 0000 0010 1
0 0020 0000 0020 0
0 0011 0000 beef 0
1 0128 cafe 0000 0
0 0129 0000 0129 1
0 0128 0000 cafe 1
0 012b 0000 012b 1
1 003d 5a5a 0000 0
0 043d 0000 5a5a 0
0 043c 0000 003c 1
0 0411 0000 beef 0
0 0011 0000 beef 0
1 1235 1357 0000 0
0 1235 0000 1357 1
0 f234 0000 0234 0
0 f235 0000 1357 1
0 0128 0000 cafe 1
0 0003 0000 0003 0
f 0000 0000 0000 0

/* sources.f */
rtl/cpu_pkg.sv
rtl/cache_pkg.sv
rtl/apb_cache_port.sv
rtl/cache_ctrl.sv
rtl/line_store.sv
rtl/main_memory.sv
rtl/mem_subsystem.sv
dv/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - rtl/cpu_pkg.sv
  - rtl/cache_pkg.sv
  - rtl/apb_cache_port.sv
  - rtl/cache_ctrl.sv
  - rtl/line_store.sv
  - rtl/main_memory.sv
  - rtl/mem_subsystem.sv
  - target: simulation
    files:
      - dv/tb_mem_subsystem.sv

/* dv/tb_mem_subsystem.sv */
`default_nettype none

module tb_mem_subsystem
   import cpu_pkg::*;
   import cache_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_PATTERNS = 32;
   localparam int FIELDS       = 5;      // op, addr, wdata, expected, hit
   localparam logic [15:0] OP_WRITE = 16'h0001;
   localparam logic [15:0] OP_END   = 16'h000f;

   logic  clk;
   logic  reset_n;
   logic  psel;
   logic  penable;
   logic  pwrite;
   word_t paddr;
   word_t pwdata;
   logic  pready;
   word_t prdata;

   logic [15:0] patterns [MAX_PATTERNS*FIELDS];
   int          num_patterns;
   bit          loaded = 1'b0;
   bit          access_ok;
   int          pass_count;
   int          fail_count;

   mem_subsystem dut (
      .clk     (clk),
      .reset_n (reset_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .pready  (pready),
      .prdata  (prdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // pready may only be high in the last access cycle
   task automatic check_pready_low();
      assert (pready == 1'b0) else begin
         $display("CHECK FAILED pready expected %h actual %h", 1'b0, pready);
         access_ok = 1'b0;
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      @(negedge clk);
      check_pready_low();
   endtask

   // setup, then access until pready; cycles counts from the first access cycle
   task automatic run_transfer(input logic wr, input word_t addr, input word_t wdata,
                               output word_t rd, output int cycles);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(negedge clk);
      check_pready_low(); // no leftover pulse from the transfer before
      @(posedge clk);
      penable <= 1'b1;
      cycles = 0;
      @(negedge clk);
      while (!pready) begin
         cycles++;
         @(negedge clk);
      end
      rd = prdata;
   endtask

   initial begin
      logic  is_write;
      logic  exp_hit;
      word_t addr;
      word_t wdata;
      word_t exp_data;
      word_t rd;
      int    cycles;
      int    gap;

      void'($urandom(91));
      reset_n = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      pass_count = 0;
      fail_count = 0;

      $readmemh("dv/access_patterns.hex", patterns);
      num_patterns = 0;
      while (num_patterns < MAX_PATTERNS && patterns[num_patterns*FIELDS] != OP_END)
         num_patterns++;
      assert (num_patterns > 0) else begin
         $display("no access patterns could be loaded from the pattern file");
         fail_count++;
      end
      loaded = 1'b1;

      repeat (16) @(posedge clk);
      reset_n <= 1'b1;

      for (int i = 0; i < num_patterns; i++) begin
         is_write  = (patterns[i*FIELDS] == OP_WRITE);
         addr      = patterns[i*FIELDS+1];
         wdata     = patterns[i*FIELDS+2];
         exp_data  = patterns[i*FIELDS+3];
         exp_hit   = patterns[i*FIELDS+4][0];
         access_ok = 1'b1;

         gap = $urandom % 4; // 0 to 3 idle cycles
         repeat (gap) idle_cycle();
         run_transfer(is_write, addr, wdata, rd, cycles);

         if (!is_write) begin
            assert (rd == exp_data) else begin
               $display("CHECK FAILED prdata expected %h actual %h", exp_data, rd);
               access_ok = 1'b0;
            end
         end
         if (exp_hit) begin
            assert (cycles == 1) else begin
               $display("access %0d was expected to be a hit but took %0d cycles", i, cycles);
               access_ok = 1'b0;
            end
         end else begin
            assert (cycles > 1) else begin
               $display("access %0d was expected to be a miss but completed at once", i);
               access_ok = 1'b0;
            end
         end

         $display("access %0d %s addr %h data %h cycles %0d %s", i,
                  is_write ? "write" : "read ", addr, is_write ? wdata : rd, cycles,
                  access_ok ? "ok" : "FAILED");
         if (access_ok)
            pass_count++;
         else
            fail_count++;
      end

      // bus released, nothing may follow
      access_ok = 1'b1;
      idle_cycle();
      idle_cycle();
      if (!access_ok)
         fail_count++;

      $display("accesses passed %0d failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

   // watchdog, budget per access covers a write miss plus setup and gaps
   initial begin
      int limit;
      wait (loaded);
      limit = num_patterns * (2*MEM_LATENCY + 9 + 3) + 40;
      wait (reset_n === 1'b1);
      repeat (limit) @(posedge clk);
      $display("the run timed out after %0d cycles before all accesses finished", limit);
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/mem_subsystem.sv */
`default_nettype none

module mem_subsystem
   import cpu_pkg::*;
   import cache_pkg::*;
(
   input  wire logic  clk,
   input  wire logic  reset_n,
   input  wire logic  psel,
   input  wire logic  penable,
   input  wire logic  pwrite,
   input  wire word_t paddr,
   input  wire word_t pwdata,
   output logic       pready,
   output word_t      prdata
);

   logic        req_valid, req_write, done;
   cache_addr_u req_addr, lookup_addr;
   word_t       req_wdata, rdata;

   logic   hit, fill_en, wr_en;
   word_t  line_rdata, wr_word;
   block_t line_block, fill_block;

   logic                    mem_read, mem_write, mem_done;
   logic [BLOCK_ADDR_W-1:0] mem_block_addr;
   block_t                  mem_wdata, mem_rdata;

   // processor side
   apb_cache_port u_port (
      .clk       (clk),
      .reset_n   (reset_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .pready    (pready),
      .prdata    (prdata),
      .req_valid (req_valid),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .done      (done),
      .rdata     (rdata)
   );

   cache_ctrl u_ctrl (
      .clk            (clk),
      .reset_n        (reset_n),
      .req_valid      (req_valid),
      .req_write      (req_write),
      .req_addr       (req_addr),
      .req_wdata      (req_wdata),
      .done           (done),
      .rdata          (rdata),
      .lookup_addr    (lookup_addr),
      .hit            (hit),
      .line_rdata     (line_rdata),
      .line_block     (line_block),
      .fill_en        (fill_en),
      .fill_block     (fill_block),
      .wr_en          (wr_en),
      .wr_word        (wr_word),
      .mem_read       (mem_read),
      .mem_write      (mem_write),
      .mem_block_addr (mem_block_addr),
      .mem_wdata      (mem_wdata),
      .mem_rdata      (mem_rdata),
      .mem_done       (mem_done)
   );

   line_store u_store (
      .clk         (clk),
      .reset_n     (reset_n),
      .lookup_addr (lookup_addr),
      .hit         (hit),
      .line_rdata  (line_rdata),
      .line_block  (line_block),
      .fill_en     (fill_en),
      .fill_block  (fill_block),
      .wr_en       (wr_en),
      .wr_word     (wr_word)
   );

   // backing store, fixed latency
   main_memory u_mem (
      .clk            (clk),
      .reset_n        (reset_n),
      .mem_read       (mem_read),
      .mem_write      (mem_write),
      .mem_block_addr (mem_block_addr),
      .mem_wdata      (mem_wdata),
      .mem_rdata      (mem_rdata),
      .mem_done       (mem_done)
   );

endmodule

`default_nettype wire

/* rtl/main_memory.sv */
`default_nettype none

module main_memory
   import cpu_pkg::*;
   import cache_pkg::*;
(
   input  wire logic                    clk,
   input  wire logic                    reset_n,
   input  wire logic                    mem_read,
   input  wire logic                    mem_write,
   input  wire logic [BLOCK_ADDR_W-1:0] mem_block_addr,
   input  wire block_t                  mem_wdata,
   output block_t                       mem_rdata,
   output logic                         mem_done
);

   block_t mem [MEM_BLOCKS];

   logic [$clog2(MEM_LATENCY)-1:0] count; // cycles the request has been up
   logic [$clog2(MEM_BLOCKS)-1:0]  mem_idx;
   logic                           active;
   logic                           finish;

   assign mem_idx = mem_block_addr[$clog2(MEM_BLOCKS)-1:0]; // upper bits alias
   assign active  = mem_read || mem_write;
   // last cycle before mem_done
   assign finish  = active && !mem_done && (count == $bits(count)'(MEM_LATENCY - 2));

   // each word holds its own word address
   initial begin
      for (int b = 0; b < MEM_BLOCKS; b++)
         for (int o = 0; o < (1 << OFFSET_W); o++)
            mem[b][o] = word_t'((b << OFFSET_W) + o);
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         count    <= '0;
         mem_done <= 1'b0;
      end else begin
         mem_done <= finish;
         if (!active || mem_done)
            count <= '0;
         else
            count <= count + 1'b1;
      end
   end

   always @(posedge clk) begin
      if (finish && mem_write)
         mem[mem_idx] <= mem_wdata;
   end

   always_ff @(posedge clk) begin
      if (finish && !mem_write)
         mem_rdata <= mem[mem_idx]; // held until the next read completes
   end

endmodule

`default_nettype wire

/* rtl/line_store.sv */
`default_nettype none

module line_store
   import cpu_pkg::*;
   import cache_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_n,
   input  wire cache_addr_u lookup_addr,
   output logic             hit,
   output word_t            line_rdata,
   output block_t           line_block,
   input  wire logic        fill_en,
   input  wire block_t      fill_block,
   input  wire logic        wr_en,
   input  wire word_t       wr_word
);

   block_t               data_bank [NUM_LINES];
   logic [TAG_W-1:0]     tag_bank  [NUM_LINES];
   logic [NUM_LINES-1:0] valid;

   logic [INDEX_W-1:0]  idx;
   logic [OFFSET_W-1:0] off;
   logic [TAG_W-1:0]    tag;

   assign idx = lookup_addr.cache_fields.index;
   assign off = lookup_addr.cache_fields.offset;
   assign tag = lookup_addr.cache_fields.tag;

   assign line_block = data_bank[idx];
   assign line_rdata = line_block[off]; // word select
   assign hit        = valid[idx] && (tag_bank[idx] == tag);

   always_ff @(posedge clk) begin
      if (!reset_n)
         valid <= '0;
      else if (fill_en)
         valid[idx] <= 1'b1;
   end

   always_ff @(posedge clk) begin
      if (fill_en) begin
         data_bank[idx] <= fill_block; // whole line replaced
         tag_bank[idx]  <= tag;
      end else if (wr_en) begin
         data_bank[idx][off] <= wr_word; // merge one word
      end
   end

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
`default_nettype none

module cache_ctrl
   import cpu_pkg::*;
   import cache_pkg::*;
(
   input  wire logic                     clk,
   input  wire logic                     reset_n,
   input  wire logic                     req_valid,
   input  wire logic                     req_write,
   input  wire cache_addr_u              req_addr,
   input  wire word_t                    req_wdata,
   output logic                          done,
   output word_t                         rdata,
   output cache_addr_u                   lookup_addr,
   input  wire logic                     hit,
   input  wire word_t                    line_rdata,
   input  wire block_t                   line_block,
   output logic                          fill_en,
   output block_t                        fill_block,
   output logic                          wr_en,
   output word_t                         wr_word,
   output logic                          mem_read,
   output logic                          mem_write,
   output logic [BLOCK_ADDR_W-1:0]       mem_block_addr,
   output block_t                        mem_wdata,
   input  wire block_t                   mem_rdata,
   input  wire logic                     mem_done
);

   enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL,
      FILL,
      WRITE_WORD,
      WRITE_THROUGH
   } state, state_next;

   cache_addr_u addr_q;
   logic        write_q;
   word_t       wdata_q;
   block_t      refill_q; // block fetched on a miss

   // idle looks at the live request so a read hit answers at once
   assign lookup_addr    = (state == IDLE) ? req_addr : addr_q;
   assign rdata          = line_rdata;
   assign fill_block     = refill_q;
   assign wr_word        = wdata_q;
   assign mem_block_addr = addr_q.mem_fields.block_addr;
   assign mem_wdata      = line_block; // merged line goes out whole

   always_ff @(posedge clk) begin
      if (!reset_n)
         state <= IDLE;
      else
         state <= state_next;
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && req_valid) begin
         addr_q  <= req_addr;
         write_q <= req_write;
         wdata_q <= req_wdata;
      end
      if (mem_read && mem_done)
         refill_q <= mem_rdata;
   end

   always_comb begin
      state_next = state;
      done       = 1'b0;
      fill_en    = 1'b0;
      wr_en      = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      case (state)
         IDLE: begin
            if (req_valid) begin
               if (req_write)
                  state_next = LOOKUP; // writes run from the latched copy
               else if (hit)
                  done = 1'b1;
               else
                  state_next = REFILL;
            end
         end
         LOOKUP: begin
            if (!hit) begin
               state_next = REFILL;
            end else if (write_q) begin
               state_next = WRITE_WORD;
            end else begin
               done       = 1'b1;
               state_next = IDLE;
            end
         end
         REFILL: begin
            mem_read = 1'b1;
            if (mem_done)
               state_next = FILL;
         end
         FILL: begin
            fill_en    = 1'b1;
            state_next = LOOKUP; // check again, now a hit
         end
         WRITE_WORD: begin
            wr_en      = 1'b1;
            state_next = WRITE_THROUGH;
         end
         WRITE_THROUGH: begin
            mem_write = 1'b1;
            if (mem_done) begin
               done       = 1'b1;
               state_next = IDLE;
            end
         end
         default: state_next = IDLE;
      endcase
   end

endmodule

`default_nettype wire

/* rtl/apb_cache_port.sv */
`default_nettype none

module apb_cache_port
   import cpu_pkg::*;
   import cache_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        reset_n,
   input  wire logic        psel,
   input  wire logic        penable,
   input  wire logic        pwrite,
   input  wire word_t       paddr,
   input  wire word_t       pwdata,
   output logic             pready,
   output word_t            prdata,
   output logic             req_valid,
   output logic             req_write,
   output cache_addr_u      req_addr,
   output word_t            req_wdata,
   input  wire logic        done,
   input  wire word_t       rdata
);

   logic open_q; // access phase already handed to the controller

   // one request per transfer, held off during the pready cycle as well
   assign req_valid = psel && penable && !open_q && !pready;
   assign req_write = pwrite;
   assign req_addr  = cache_addr_u'(paddr);
   assign req_wdata = pwdata;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         open_q <= 1'b0;
         pready <= 1'b0;
      end else begin
         pready <= done;
         if (done)
            open_q <= 1'b0;
         else if (req_valid)
            open_q <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (done)
         prdata <= rdata; // only meaningful for reads
   end

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

   // direct mapped, four lines of four words
   localparam int NUM_LINES = 4;
   localparam int INDEX_W   = 2;
   localparam int OFFSET_W  = 2;
   localparam int TAG_W     = 12;

   // tag and index together address one block
   localparam int BLOCK_ADDR_W = TAG_W + INDEX_W;

   localparam int MEM_LATENCY = 4;   // cycles from request to mem_done
   localparam int MEM_BLOCKS  = 256; // upper block address bits alias

   // the same 16-bit address seen by the cache and by the memory
   typedef union packed {
      struct packed {
         logic [TAG_W-1:0]    tag;
         logic [INDEX_W-1:0]  index;
         logic [OFFSET_W-1:0] offset;
      } cache_fields;
      struct packed {
         logic [BLOCK_ADDR_W-1:0] block_addr;
         logic [OFFSET_W-1:0]     offset;
      } mem_fields;
   } cache_addr_u;

endpackage

`default_nettype wire

/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

   // processor word width
   localparam int WORD_SIZE = 16;

   typedef logic [WORD_SIZE-1:0] word_t;

   // one cache block, four words
   // ascending range so that blk[0] lands in the top bits,
   // which keeps word offset 0 as the most significant word
   typedef word_t [0:3] block_t;

endpackage

`default_nettype wire
